// ==== hw/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    localparam int addr_w = 16;
    localparam int data_w = 16;

    // Shared RAM depth and its word index width
    localparam int ram_words = 1024;
    localparam int ram_aw = $clog2(ram_words);

    // One request, held until the matching ready pulse
    typedef struct packed {
        logic              valid;
        logic              we;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } bus_req_t;

    // Ready is a single-cycle strobe, rdata valid with it on reads
    typedef struct packed {
        logic              ready;
        logic [data_w-1:0] rdata;
    } bus_rsp_t;

endpackage

`default_nettype wire

// ==== hw/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int num_regs = 16;

    // Unlisted opcodes are illegal and stop the core with error
    typedef enum logic [3:0] {
        op_alu  = 4'h0,
        op_ldi  = 4'h1,
        op_ld   = 4'h2,
        op_st   = 4'h3,
        op_bnz  = 4'h4,
        op_halt = 4'h5
    } opcode_t;

    typedef enum logic [3:0] {
        fn_add = 4'h0,
        fn_sub = 4'h1,
        fn_and = 4'h2,
        fn_or  = 4'h3,
        fn_xor = 4'h4,
        fn_shl = 4'h5,
        fn_shr = 4'h6,
        fn_mul = 4'h7
    } alu_fn_t;

    // Register form: rd = rd funct rs
    typedef struct packed {
        opcode_t    opcode;
        alu_fn_t    funct;
        logic [3:0] rd;
        logic [3:0] rs;
    } instr_reg_t;

    // Immediate form for ldi and bnz
    typedef struct packed {
        opcode_t    opcode;
        logic [3:0] rd;
        logic [7:0] imm8;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t rform;
        instr_imm_t iform;
    } instr_t;

endpackage

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  isa_pkg::alu_fn_t fn,
    input  logic [15:0]      a,
    input  logic [15:0]      b,
    output logic [15:0]      y
);

    import isa_pkg::*;

    always_comb begin
        case (fn)
            fn_add: begin
                y = a + b;
            end
            fn_sub: begin
                y = a - b;
            end
            fn_and: begin
                y = a & b;
            end
            fn_or: begin
                y = a | b;
            end
            fn_xor: begin
                y = a ^ b;
            end
            // Shift amount from the low nibble of b
            fn_shl: begin
                y = a << b[3:0];
            end
            fn_shr: begin
                y = a >> b[3:0];
            end
            // Product truncated to the low half
            fn_mul: begin
                y = a * b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/cpu_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_core (
    input  logic              clk,
    input  logic              reset,
    input  logic              run,
    output bus_pkg::bus_req_t bus_req,
    input  bus_pkg::bus_rsp_t bus_rsp,
    output logic              hlt,
    output logic              error
);

    import bus_pkg::*;
    import isa_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_exec,
        st_mem,
        st_wb
    } stage_t;

    stage_t stage;
    logic [addr_w-1:0] pc;
    instr_t ir;

    logic [data_w-1:0] regs [num_regs];
    logic [data_w-1:0] rd_val;
    logic [data_w-1:0] rs_val;
    logic [data_w-1:0] res_q;
    logic [data_w-1:0] imm_ext;
    logic [data_w-1:0] alu_y;

    opcode_t op;
    logic imm_form;
    logic [3:0] dst_idx;
    logic reg_write;
    logic taken;

    assign op = ir.rform.opcode;

    // ldi and bnz carry rd in bits 11:8, the register form in bits 7:4
    assign imm_form = (op == op_ldi) || (op == op_bnz);
    assign dst_idx = imm_form ? ir.iform.rd : ir.rform.rd;
    assign imm_ext = {{(data_w - 8){ir.iform.imm8[7]}}, ir.iform.imm8};

    assign reg_write = (op == op_alu) || (op == op_ldi) || (op == op_ld);
    assign taken = (op == op_bnz) && (rd_val != '0);

    alu u_alu (
        .fn(ir.rform.funct),
        .a (rd_val),
        .b (rs_val),
        .y (alu_y)
    );

    // Fetch reads at pc, ld reads mem[rs], st writes rs to mem[rd]
    always_comb begin
        bus_req.valid = (stage == st_fetch) || (stage == st_mem);
        bus_req.we = (stage == st_mem) && (op == op_st);
        bus_req.addr = pc;
        if (stage == st_mem) begin
            bus_req.addr = (op == op_st) ? rd_val : rs_val;
        end
        bus_req.wdata = rs_val;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            stage <= st_idle;
            pc <= '0;
            hlt <= 1'b0;
            error <= 1'b0;
        end else begin
            case (stage)
                st_idle: begin
                    if (run && !hlt) begin
                        stage <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (bus_rsp.ready) begin
                        stage <= st_decode;
                    end
                end
                st_decode: begin
                    case (op)
                        op_halt: begin
                            hlt <= 1'b1;
                            stage <= st_idle;
                        end
                        op_alu, op_ldi, op_ld, op_st, op_bnz: begin
                            stage <= st_exec;
                        end
                        default: begin
                            hlt <= 1'b1;
                            error <= 1'b1;
                            stage <= st_idle;
                        end
                    endcase
                end
                st_exec: begin
                    if ((op == op_ld) || (op == op_st)) begin
                        stage <= st_mem;
                    end else begin
                        stage <= st_wb;
                    end
                end
                st_mem: begin
                    if (bus_rsp.ready) begin
                        stage <= st_wb;
                    end
                end
                st_wb: begin
                    pc <= taken ? pc + imm_ext : pc + 1'b1;
                    stage <= run ? st_fetch : st_idle;
                end
                default: begin
                    stage <= st_idle;
                end
            endcase
        end
    end

    // Instruction, operands and result
    always_ff @(posedge clk) begin
        if ((stage == st_fetch) && bus_rsp.ready) begin
            ir <= bus_rsp.rdata;
        end
        if (stage == st_decode) begin
            rd_val <= regs[dst_idx];
            rs_val <= regs[ir.rform.rs];
        end
        if (stage == st_exec) begin
            res_q <= (op == op_ldi) ? imm_ext : alu_y;
        end
        if ((stage == st_mem) && bus_rsp.ready) begin
            res_q <= bus_rsp.rdata;
        end
        if ((stage == st_wb) && reg_write) begin
            regs[dst_idx] <= res_q;
        end
    end

endmodule

`default_nettype wire

// ==== hw/bus_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  bus_pkg::bus_req_t host_req,
    output bus_pkg::bus_rsp_t host_rsp,
    input  bus_pkg::bus_req_t core_req,
    output bus_pkg::bus_rsp_t core_rsp,
    output bus_pkg::bus_req_t ram_req,
    input  bus_pkg::bus_rsp_t ram_rsp
);

    typedef enum logic [1:0] {
        gnt_idle,
        gnt_host,
        gnt_core
    } grant_t;

    grant_t grant;
    // High only in the first granted cycle, so the RAM takes each request once
    logic issue;

    always_ff @(posedge clk) begin
        if (!reset) begin
            grant <= gnt_idle;
            issue <= 1'b0;
        end else begin
            issue <= 1'b0;
            case (grant)
                gnt_idle: begin
                    if (host_req.valid) begin
                        grant <= gnt_host;
                        issue <= 1'b1;
                    end else if (core_req.valid) begin
                        grant <= gnt_core;
                        issue <= 1'b1;
                    end
                end
                default: begin
                    if (ram_rsp.ready) begin
                        grant <= gnt_idle;
                    end
                end
            endcase
        end
    end

    always_comb begin
        ram_req = (grant == gnt_host) ? host_req : core_req;
        ram_req.valid = issue;

        host_rsp.ready = ram_rsp.ready && (grant == gnt_host);
        host_rsp.rdata = ram_rsp.rdata;
        core_rsp.ready = ram_rsp.ready && (grant == gnt_core);
        core_rsp.rdata = ram_rsp.rdata;
    end

endmodule

`default_nettype wire

// ==== hw/shared_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module shared_ram (
    input  logic              clk,
    input  logic              reset,
    input  bus_pkg::bus_req_t req,
    output bus_pkg::bus_rsp_t rsp
);

    import bus_pkg::*;

    logic [data_w-1:0] mem [ram_words];
    logic [data_w-1:0] rdata_q;
    logic ready_q;

    // Address wraps onto the RAM depth
    always_ff @(posedge clk) begin
        if (req.valid) begin
            if (req.we) begin
                mem[req.addr[ram_aw-1:0]] <= req.wdata;
            end
            rdata_q <= mem[req.addr[ram_aw-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= req.valid;
        end
    end

    assign rsp.ready = ready_q;
    assign rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== hw/tiny16_system.sv ====
`timescale 1ns/10ps
`default_nettype none

module tiny16_system (
    input  logic              clk,
    input  logic              reset,
    input  logic              run,
    input  bus_pkg::bus_req_t host_req,
    output bus_pkg::bus_rsp_t host_rsp,
    output logic              hlt,
    output logic              error
);

    import bus_pkg::*;

    bus_req_t core_req;
    bus_rsp_t core_rsp;
    bus_req_t ram_req;
    bus_rsp_t ram_rsp;

    cpu_core u_core (
        .clk    (clk),
        .reset  (reset),
        .run    (run),
        .bus_req(core_req),
        .bus_rsp(core_rsp),
        .hlt    (hlt),
        .error  (error)
    );

    // Host has priority over the core
    bus_arbiter u_arbiter (
        .clk     (clk),
        .reset   (reset),
        .host_req(host_req),
        .host_rsp(host_rsp),
        .core_req(core_req),
        .core_rsp(core_rsp),
        .ram_req (ram_req),
        .ram_rsp (ram_rsp)
    );

    shared_ram u_ram (
        .clk  (clk),
        .reset(reset),
        .req  (ram_req),
        .rsp  (ram_rsp)
    );

endmodule

`default_nettype wire

// ==== sim/tb_tiny16_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_tiny16_assert (
    input logic              clk,
    input logic              reset,
    input bus_pkg::bus_req_t host_req,
    input bus_pkg::bus_rsp_t host_rsp,
    input bus_pkg::bus_req_t core_req,
    input bus_pkg::bus_rsp_t core_rsp,
    input bus_pkg::bus_req_t ram_req,
    input bus_pkg::bus_rsp_t ram_rsp
);

    int fails = 0;

    // Each RAM response reaches exactly one requester
    assert property (@(posedge clk) disable iff (!reset)
        ram_rsp.ready |-> (host_rsp.ready ^ core_rsp.ready))
    else begin
        fails++;
        $error("RAM ready did not reach exactly one of host and core");
    end

    assert property (@(posedge clk) disable iff (!reset)
        host_rsp.ready |-> host_req.valid)
    else begin
        fails++;
        $error("Host saw ready without a valid request");
    end

    assert property (@(posedge clk) disable iff (!reset)
        core_rsp.ready |-> core_req.valid)
    else begin
        fails++;
        $error("Core saw ready without a valid request");
    end

    // Waiting requests hold their fields
    assert property (@(posedge clk) disable iff (!reset)
        (host_req.valid && !host_rsp.ready) |=> $stable(host_req))
    else begin
        fails++;
        $error("Host request changed before its ready");
    end

    assert property (@(posedge clk) disable iff (!reset)
        (core_req.valid && !core_rsp.ready) |=> $stable(core_req))
    else begin
        fails++;
        $error("Core request changed before its ready");
    end

    assert property (@(posedge clk) disable iff (!reset)
        ram_req.valid |=> (ram_rsp.ready && !ram_req.valid))
    else begin
        fails++;
        $error("RAM saw a second valid while a response was pending");
    end

endmodule

`default_nettype wire

// ==== sim/tb_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_checker (
    input  logic              clk,
    input  logic              reset,
    input  logic [7:0]        test_id,
    input  bus_pkg::bus_req_t host_req,
    input  bus_pkg::bus_rsp_t host_rsp,
    input  logic              hlt,
    input  logic              error,
    output int                errors
);

    import bus_pkg::*;
    import isa_pkg::*;

    localparam int max_steps = 4000;

    // Memory as the host and the model see it
    logic [data_w-1:0] image [ram_words];
    logic exp_hlt;
    logic exp_err;
    logic hlt_q;
    int err_cnt = 0;

    assign errors = err_cnt;

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'd1: return "host_rw";
            8'd2: return "alu_program";
            8'd3: return "load_loop";
            8'd4: return "illegal_op";
            8'd5: return "contention";
            default: return "unknown";
        endcase
    endfunction

    function automatic logic [15:0] sext8(input logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    function automatic logic [15:0] alu_model(input logic [3:0] fn, input logic [15:0] a,
                                              input logic [15:0] b);
        logic [31:0] p;
        p = 32'(a) * 32'(b);
        case (fn)
            fn_add: return a + b;
            fn_sub: return a - b;
            fn_and: return a & b;
            fn_or: return a | b;
            fn_xor: return a ^ b;
            fn_shl: return a << b[3:0];
            fn_shr: return a >> b[3:0];
            fn_mul: return p[15:0];
            default: return 16'h0000;
        endcase
    endfunction

    // Executes the image from address 0, stores land in the image itself
    function automatic void run_reference();
        logic [15:0] r [num_regs];
        logic [15:0] pc;
        logic [15:0] npc;
        logic [15:0] w;
        logic [3:0] ra;
        logic [3:0] rb;
        int steps;
        foreach (r[i]) begin
            r[i] = '0;
        end
        pc = '0;
        steps = 0;
        exp_hlt = 1'b0;
        exp_err = 1'b0;
        while (!exp_hlt && steps < max_steps) begin
            w = image[pc[ram_aw-1:0]];
            ra = w[7:4];
            rb = w[3:0];
            npc = pc + 16'd1;
            steps++;
            case (w[15:12])
                op_alu: r[ra] = alu_model(w[11:8], r[ra], r[rb]);
                op_ldi: r[w[11:8]] = sext8(w[7:0]);
                op_ld: r[ra] = image[r[rb][ram_aw-1:0]];
                op_st: image[r[ra][ram_aw-1:0]] = r[rb];
                op_bnz: begin
                    if (r[w[11:8]] != '0) begin
                        npc = pc + sext8(w[7:0]);
                    end
                end
                op_halt: exp_hlt = 1'b1;
                default: begin
                    exp_hlt = 1'b1;
                    exp_err = 1'b1;
                end
            endcase
            pc = npc;
        end
    endfunction

    always @(posedge clk) begin
        if (!reset) begin
            hlt_q <= 1'b0;
        end else begin
            hlt_q <= hlt;
            if (host_req.valid && host_rsp.ready && host_req.we) begin
                image[host_req.addr[ram_aw-1:0]] = host_req.wdata;
            end
            if (host_req.valid && host_rsp.ready && !host_req.we &&
                (host_rsp.rdata !== image[host_req.addr[ram_aw-1:0]])) begin
                err_cnt++;
                $display("Error %s: read at %h expected %h, actual %h", test_name(test_id),
                         host_req.addr, image[host_req.addr[ram_aw-1:0]], host_rsp.rdata);
            end
            if (hlt && !hlt_q) begin
                run_reference();
                if (!exp_hlt) begin
                    err_cnt++;
                    $display("Reference model for %s never reached a halt", test_name(test_id));
                end
                if (error !== exp_err) begin
                    err_cnt++;
                    $display("Error %s: error flag expected %b, actual %b", test_name(test_id),
                             exp_err, error);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_tiny16.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_tiny16;

    import bus_pkg::*;
    import isa_pkg::*;

    localparam int bus_timeout = 50;
    localparam int run_timeout = 5000;

    logic clk;
    logic reset;
    logic run;
    bus_req_t host_req;
    bus_rsp_t host_rsp;
    logic hlt;
    logic error;
    logic [7:0] test_id;
    logic [15:0] lfsr;
    logic [15:0] prog [$];
    int check_errors;
    int timeouts;

    tiny16_system uut (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .host_req(host_req),
        .host_rsp(host_rsp),
        .hlt     (hlt),
        .error   (error)
    );

    tb_checker u_checker (
        .clk     (clk),
        .reset   (reset),
        .test_id (test_id),
        .host_req(host_req),
        .host_rsp(host_rsp),
        .hlt     (hlt),
        .error   (error),
        .errors  (check_errors)
    );

    bind bus_arbiter tb_tiny16_assert arb_assert (
        .clk     (clk),
        .reset   (reset),
        .host_req(host_req),
        .host_rsp(host_rsp),
        .core_req(core_req),
        .core_rsp(core_rsp),
        .ram_req (ram_req),
        .ram_rsp (ram_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [15:0] next_lfsr(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [15:0] enc_reg(input logic [3:0] op, input logic [3:0] fn,
                                            input logic [3:0] rd, input logic [3:0] rs);
        return {op, fn, rd, rs};
    endfunction

    function automatic logic [15:0] enc_imm(input logic [3:0] op, input logic [3:0] rd,
                                            input logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    task automatic finish_run();
        int total;
        total = check_errors + timeouts + uut.u_arbiter.arb_assert.fails;
        $display("Checker errors: %0d, assertion failures: %0d, timeouts: %0d",
                 check_errors, uut.u_arbiter.arb_assert.fails, timeouts);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b1;
    endtask

    task automatic host_access(input logic we, input logic [15:0] addr,
                               input logic [15:0] wdata);
        int cycles;
        cycles = 0;
        @(negedge clk);
        host_req.valid = 1'b1;
        host_req.we = we;
        host_req.addr = addr;
        host_req.wdata = wdata;
        @(posedge clk);
        while (!host_rsp.ready && cycles < bus_timeout) begin
            cycles++;
            @(posedge clk);
        end
        if (!host_rsp.ready) begin
            $display("Host access at address %h got no ready within %0d cycles",
                     addr, bus_timeout);
            timeouts++;
            finish_run();
        end else begin
            @(negedge clk);
            host_req.valid = 1'b0;
        end
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            host_access(1'b1, 16'(i), prog[i]);
        end
    endtask

    task automatic read_range(input logic [15:0] base, input int n);
        for (int i = 0; i < n; i++) begin
            host_access(1'b0, base + 16'(i), '0);
        end
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (!hlt && cycles < run_timeout) begin
            cycles++;
            @(negedge clk);
        end
        if (!hlt) begin
            $display("Core did not halt within %0d cycles", run_timeout);
            timeouts++;
            finish_run();
        end else begin
            run = 1'b0;
        end
    endtask

    task automatic start_core();
        @(negedge clk);
        run = 1'b1;
    endtask

    task automatic test_host_rw();
        logic [15:0] addrs [$];
        logic [15:0] a;
        test_id = 8'd1;
        repeat (16) begin
            a = random_bits(10);
            addrs.push_back(a);
            host_access(1'b1, a, random_bits(16));
        end
        foreach (addrs[i]) begin
            host_access(1'b0, addrs[i], '0);
        end
    endtask

    // r0 is the store pointer, random ALU ops write r1 to r15 only
    task automatic test_alu_program();
        logic [3:0] fn;
        logic [3:0] rd;
        test_id = 8'd2;
        apply_reset();
        prog.delete();
        prog.push_back(enc_imm(op_ldi, 4'd0, 8'h60));
        for (int i = 1; i < num_regs; i++) begin
            prog.push_back(enc_imm(op_ldi, 4'(i), 8'(random_bits(8))));
        end
        for (int i = 0; i < 24; i++) begin
            fn = (i < 8) ? 4'(i) : 4'(random_bits(4));
            rd = 4'(1 + (random_bits(4) % 15));
            prog.push_back(enc_reg(op_alu, fn, rd, 4'(random_bits(4))));
        end
        prog.push_back(enc_reg(op_st, 4'd0, 4'd0, 4'd0));
        for (int i = 1; i < num_regs; i++) begin
            prog.push_back(enc_imm(op_ldi, 4'd0, 8'(8'h60 + i)));
            prog.push_back(enc_reg(op_st, 4'd0, 4'd0, 4'(i)));
        end
        prog.push_back(enc_imm(op_halt, 4'd0, 8'h00));
        load_program();
        start_core();
        wait_for_halt();
        read_range(16'h0060, num_regs);
    endtask

    task automatic test_load_loop();
        test_id = 8'd3;
        apply_reset();
        host_access(1'b1, 16'h0070, random_bits(16));
        host_access(1'b1, 16'h0071, random_bits(16));
        prog.delete();
        prog.push_back(enc_imm(op_ldi, 4'd0, 8'h70));
        prog.push_back(enc_reg(op_ld, 4'd0, 4'd1, 4'd0));
        prog.push_back(enc_imm(op_ldi, 4'd0, 8'h71));
        prog.push_back(enc_reg(op_ld, 4'd0, 4'd2, 4'd0));
        prog.push_back(enc_reg(op_alu, fn_add, 4'd1, 4'd2));
        prog.push_back(enc_imm(op_ldi, 4'd3, 8'(3 + random_bits(3))));
        prog.push_back(enc_imm(op_ldi, 4'd4, 8'h00));
        prog.push_back(enc_imm(op_ldi, 4'd5, 8'h01));
        prog.push_back(enc_imm(op_ldi, 4'd6, 8'hff));
        // Loop body, r3 counts down and r4 counts iterations
        prog.push_back(enc_reg(op_alu, fn_add, 4'd4, 4'd5));
        prog.push_back(enc_reg(op_alu, fn_mul, 4'd1, 4'd2));
        prog.push_back(enc_reg(op_alu, fn_add, 4'd3, 4'd6));
        prog.push_back(enc_imm(op_bnz, 4'd3, 8'hfd));
        for (int i = 0; i < 3; i++) begin
            prog.push_back(enc_imm(op_ldi, 4'd0, 8'(8'h74 + i)));
            prog.push_back(enc_reg(op_st, 4'd0, 4'd0, (i == 0) ? 4'd1 : 4'(2 + i)));
        end
        prog.push_back(enc_imm(op_halt, 4'd0, 8'h00));
        load_program();
        start_core();
        wait_for_halt();
        read_range(16'h0074, 3);
    endtask

    task automatic test_illegal_op();
        logic [3:0] bad_op;
        logic [11:0] bad_low;
        test_id = 8'd4;
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            host_access(1'b1, 16'h0040 + 16'(i), (16'h0040 + 16'(i)) ^ 16'hc3a5);
        end
        bad_op = 4'(6 + random_bits(3));
        bad_low = 12'(random_bits(12));
        prog.delete();
        prog.push_back(enc_imm(op_ldi, 4'd1, 8'(random_bits(8))));
        prog.push_back(enc_imm(op_ldi, 4'd2, 8'(random_bits(8))));
        for (int i = 0; i < 4; i++) begin
            // Stores past the illegal word must never happen
            if (i == 2) begin
                prog.push_back({bad_op, bad_low});
            end
            prog.push_back(enc_imm(op_ldi, 4'd0, 8'(8'h40 + i)));
            prog.push_back(enc_reg(op_st, 4'd0, 4'd0, 4'(1 + (i % 2))));
        end
        prog.push_back(enc_imm(op_halt, 4'd0, 8'h00));
        load_program();
        start_core();
        wait_for_halt();
        read_range(16'h0040, 4);
    endtask

    task automatic test_contention();
        test_id = 8'd5;
        apply_reset();
        prog.delete();
        for (int i = 0; i < 4; i++) begin
            prog.push_back(enc_imm(op_ldi, 4'(i), 8'(random_bits(8))));
        end
        prog.push_back(enc_imm(op_ldi, 4'd8, 8'h50));
        prog.push_back(enc_imm(op_ldi, 4'd9, 8'h01));
        for (int i = 0; i < 12; i++) begin
            prog.push_back(enc_reg(op_st, 4'd0, 4'd8, 4'(i % 4)));
            prog.push_back(enc_reg(op_alu, fn_add, 4'd8, 4'd9));
        end
        prog.push_back(enc_imm(op_halt, 4'd0, 8'h00));
        load_program();
        start_core();
        // Program words stay untouched, so they can be read back mid-run
        read_range(16'h0000, prog.size());
        wait_for_halt();
        read_range(16'h0050, 12);
    endtask

    initial begin
        reset = 1'b0;
        run = 1'b0;
        host_req = '0;
        test_id = 8'd0;
        timeouts = 0;
        lfsr = 16'd33942;
        apply_reset();
        test_host_rw();
        test_alu_program();
        test_load_loop();
        test_illegal_op();
        test_contention();
        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/bus_pkg.sv
hw/isa_pkg.sv
hw/alu.sv
hw/cpu_core.sv
hw/bus_arbiter.sv
hw/shared_ram.sv
hw/tiny16_system.sv
sim/tb_tiny16_assert.sv
sim/tb_checker.sv
sim/tb_tiny16.sv

// ==== Bender.yml ====
package:
  name: tiny16

sources:
  - files:
      - hw/bus_pkg.sv
      - hw/isa_pkg.sv
      - hw/alu.sv
      - hw/cpu_core.sv
      - hw/bus_arbiter.sv
      - hw/shared_ram.sv
      - hw/tiny16_system.sv
  - target: simulation
    files:
      - sim/tb_tiny16_assert.sv
      - sim/tb_checker.sv
      - sim/tb_tiny16.sv
